//--- include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Word and bus width
`define DATA_WIDTH 32

// Memory geometry
`define ADDR_WIDTH 9
`define MEM_DEPTH 512

// General register count
`define REG_COUNT 8

`endif

//--- src/cpuPkg.sv
package cpuPkg;

    // Instruction opcodes, anything else decodes as HALT
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opOut  = 5'b10111,
        opHalt = 5'b11011
    } opcodeT;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluOr  = 2'd3
    } aluOpT;

    // Field order from MSB down
    typedef struct packed {
        opcodeT      opcode;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [2:0]  rc;
        logic [17:0] constant; // Sign-extended onto the bus
    } instrT;

    typedef struct packed {
        logic  pcOut, mdrOut, zOut, cOut, regOut;                       // Bus drivers
        logic  pcIn, marIn, mdrIn, irIn, yIn, zIn, regIn, outPortIn;    // Bus loads
        logic  selA, selB, selC;                                        // Register field select
        logic  incPc;
        logic  memRead;
        logic  memWrite;
        logic  mdrFromMem;
        aluOpT aluOp;
    } controlWordT;

endpackage

//--- src/registerFile.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module registerFile (
    input  logic                   Clock,
    input  logic                   reset,
    input  cpuPkg::controlWordT    control,
    input  cpuPkg::instrT          instruction,
    input  logic [`DATA_WIDTH-1:0] bus,
    output logic [`DATA_WIDTH-1:0] regData
);

    logic [`DATA_WIDTH-1:0]       regs [`REG_COUNT];
    logic [$clog2(`REG_COUNT)-1:0] regIndex;

    always_comb begin
        if (control.selA) regIndex = instruction.ra;
        else if (control.selB) regIndex = instruction.rb;
        else regIndex = instruction.rc; // selC
    end

    assign regData = control.regOut ? regs[regIndex] : '0;

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
        end else if (control.regIn) begin
            regs[regIndex] <= bus; // Write back from bus
        end
    end

    // The sequencer must name exactly one field for any register access
    regSelectOneHot: assert property (@(posedge Clock) disable iff (reset)
        (control.regIn || control.regOut) |-> $onehot({control.selA, control.selB, control.selC}));

endmodule

//--- src/aluUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module aluUnit (
    input  logic [`DATA_WIDTH-1:0] yValue,
    input  logic [`DATA_WIDTH-1:0] bus,
    input  cpuPkg::aluOpT          aluOp,
    input  logic                   incPc,
    output logic [`DATA_WIDTH-1:0] aluResult
);

    logic [`DATA_WIDTH-1:0] opResult;

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: begin
                opResult = yValue + bus; // Wraps modulo 2^32
            end
            cpuPkg::aluSub: begin
                opResult = yValue - bus;
            end
            cpuPkg::aluAnd: begin
                opResult = yValue & bus;
            end
            cpuPkg::aluOr: begin
                opResult = yValue | bus;
            end
            default: begin
                opResult = '0;
            end
        endcase
    end

    // PC increment overrides the selected operation during fetch
    always_comb begin
        if (incPc) aluResult = bus + `DATA_WIDTH'(1);
        else aluResult = opResult;
    end

endmodule

//--- src/busDatapath.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module busDatapath (
    input  logic                   Clock,
    input  logic                   reset,
    input  cpuPkg::controlWordT    control,
    input  logic [`DATA_WIDTH-1:0] regData,
    input  logic [`DATA_WIDTH-1:0] aluResult,
    input  logic [`DATA_WIDTH-1:0] memData,
    output logic [`DATA_WIDTH-1:0] bus,
    output logic [`DATA_WIDTH-1:0] yValue,
    output logic [`DATA_WIDTH-1:0] marAddress,
    output logic [`DATA_WIDTH-1:0] mdrValue,
    output logic [`DATA_WIDTH-1:0] outData,
    output cpuPkg::instrT          instruction,
    output logic                   outValid
);

    logic [`DATA_WIDTH-1:0] pcReg;
    logic [`DATA_WIDTH-1:0] marReg;
    logic [`DATA_WIDTH-1:0] mdrReg;
    logic [`DATA_WIDTH-1:0] yReg;
    logic [`DATA_WIDTH-1:0] zReg;
    logic [`DATA_WIDTH-1:0] outReg;
    logic [`DATA_WIDTH-1:0] constExt;
    cpuPkg::instrT          irReg;
    logic                   outValidReg;

    assign constExt = `DATA_WIDTH'(signed'(irReg.constant)); // Sign extend C field

    // Single shared bus
    always_comb begin
        bus = '0;
        if (control.pcOut) bus = pcReg;
        if (control.mdrOut) bus = mdrReg;
        if (control.zOut) bus = zReg;
        if (control.cOut) bus = constExt;
        if (control.regOut) bus = regData;
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            pcReg       <= '0;
            irReg       <= '0;
            marReg      <= '0;
            mdrReg      <= '0;
            yReg        <= '0;
            zReg        <= '0;
            outReg      <= '0;
            outValidReg <= 1'b0;
        end else begin
            if (control.pcIn) pcReg <= bus;
            if (control.irIn) irReg <= bus;
            if (control.marIn) marReg <= bus;
            if (control.mdrIn) begin
                mdrReg <= control.mdrFromMem ? memData : bus; // Memory or bus source
            end
            if (control.yIn) yReg <= bus;
            if (control.zIn) zReg <= aluResult;
            if (control.outPortIn) outReg <= bus;
            outValidReg <= control.outPortIn; // One-cycle pulse with new value
        end
    end

    assign yValue      = yReg;
    assign marAddress  = marReg;
    assign mdrValue    = mdrReg;
    assign outData     = outReg;
    assign instruction = irReg;
    assign outValid    = outValidReg;

    // Sequencer and register file together must never fight over the bus
    busSingleDriver: assert property (@(posedge Clock) disable iff (reset)
        $onehot0({control.pcOut, control.mdrOut, control.zOut, control.cOut, control.regOut}));

endmodule

//--- src/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
    input  logic                Clock,
    input  logic                reset,
    input  cpuPkg::instrT       instruction,
    output cpuPkg::controlWordT control,
    output logic                halted
);

    logic [3:0]    step;
    logic [3:0]    lastStep;
    logic          isRegAlu, isImmAlu, isLoad, isStore, isOut, isHalt;
    cpuPkg::aluOpT aluSel;

    // Instruction class and ALU operation
    always_comb begin
        {isRegAlu, isImmAlu, isLoad, isStore, isOut, isHalt} = '0;
        aluSel = cpuPkg::aluAdd;
        case (instruction.opcode)
            cpuPkg::opAdd: isRegAlu = 1'b1;
            cpuPkg::opSub: begin
                isRegAlu = 1'b1;
                aluSel   = cpuPkg::aluSub;
            end
            cpuPkg::opAnd: begin
                isRegAlu = 1'b1;
                aluSel   = cpuPkg::aluAnd;
            end
            cpuPkg::opOr: begin
                isRegAlu = 1'b1;
                aluSel   = cpuPkg::aluOr;
            end
            cpuPkg::opAddi: isImmAlu = 1'b1;
            cpuPkg::opAndi: begin
                isImmAlu = 1'b1;
                aluSel   = cpuPkg::aluAnd;
            end
            cpuPkg::opOri: begin
                isImmAlu = 1'b1;
                aluSel   = cpuPkg::aluOr;
            end
            cpuPkg::opLd: isLoad = 1'b1;
            cpuPkg::opSt: isStore = 1'b1;
            cpuPkg::opOut: isOut = 1'b1;
            default: isHalt = 1'b1; // HALT and unused codes
        endcase
    end

    always_comb begin
        if (isLoad) lastStep = 4'd9;
        else if (isStore) lastStep = 4'd8;
        else if (isRegAlu || isImmAlu) lastStep = 4'd6;
        else lastStep = 4'd4; // OUT, HALT
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            step   <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (step == 4'd4 && isHalt) halted <= 1'b1; // Freeze until reset
            if (step == lastStep) step <= '0;
            else step <= step + 4'd1;
        end
    end

    // One control word per step
    always_comb begin
        control = '0;
        if (!halted) begin
            case (step)
                4'd0: begin
                    control.pcOut = 1'b1;
                    control.marIn = 1'b1;
                    control.incPc = 1'b1;
                    control.zIn   = 1'b1; // Z gets PC+1
                end
                4'd1: begin
                    control.zOut    = 1'b1;
                    control.pcIn    = 1'b1;
                    control.memRead = 1'b1;
                end
                4'd2: begin
                    control.mdrIn      = 1'b1;
                    control.mdrFromMem = 1'b1;
                end
                4'd3: begin
                    control.mdrOut = 1'b1;
                    control.irIn   = 1'b1;
                end
                4'd4: begin
                    if (isOut) begin
                        control.regOut    = 1'b1;
                        control.selA      = 1'b1;
                        control.outPortIn = 1'b1;
                    end else if (!isHalt) begin
                        control.regOut = 1'b1;
                        control.selB   = 1'b1;
                        control.yIn    = 1'b1; // Base or first operand
                    end
                end
                4'd5: begin
                    control.zIn   = 1'b1;
                    control.aluOp = aluSel;
                    if (isRegAlu) begin
                        control.regOut = 1'b1;
                        control.selC   = 1'b1;
                    end else begin
                        control.cOut = 1'b1;
                    end
                end
                4'd6: begin
                    control.zOut = 1'b1;
                    if (isLoad || isStore) begin
                        control.marIn = 1'b1; // Effective address
                    end else begin
                        control.regIn = 1'b1;
                        control.selA  = 1'b1;
                    end
                end
                4'd7: begin
                    if (isLoad) begin
                        control.memRead = 1'b1;
                    end else begin
                        control.regOut = 1'b1;
                        control.selA   = 1'b1;
                        control.mdrIn  = 1'b1; // Store data
                    end
                end
                4'd8: begin
                    if (isLoad) begin
                        control.mdrIn      = 1'b1;
                        control.mdrFromMem = 1'b1;
                    end else begin
                        control.memWrite = 1'b1;
                    end
                end
                4'd9: begin
                    control.mdrOut = 1'b1;
                    control.regIn  = 1'b1;
                    control.selA   = 1'b1;
                end
                default: ;
            endcase
        end
    end

    memNoConflict: assert property (@(posedge Clock) disable iff (reset)
        !(control.memRead && control.memWrite));

endmodule

//--- src/memory512x32.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memory512x32 (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   memRead,
    input  logic                   memWrite,
    input  logic                   loadEnable,
    input  logic [`ADDR_WIDTH-1:0] address,
    input  logic [`ADDR_WIDTH-1:0] loadAddress,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic [`DATA_WIDTH-1:0] loadData,
    output logic [`DATA_WIDTH-1:0] readData
);

    logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

    always_ff @(posedge Clock) begin
        if (reset) begin
            if (loadEnable) mem[loadAddress] <= loadData; // Preload port
        end else begin
            if (memWrite) mem[address] <= writeData;
            if (memRead) readData <= mem[address]; // Valid next cycle
        end
    end

    // Preload only while the core is held in reset
    preloadInReset: assert property (@(posedge Clock) loadEnable |-> reset);

endmodule

//--- src/miniCpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module miniCpu (
    input  logic                   Clock,
    input  logic                   reset,
    input  logic                   loadEnable,
    input  logic [`ADDR_WIDTH-1:0] loadAddress,
    input  logic [`DATA_WIDTH-1:0] loadData,
    output logic [`DATA_WIDTH-1:0] outData,
    output logic                   outValid,
    output logic                   halted
);

    cpuPkg::controlWordT    control;
    cpuPkg::instrT          instruction;
    logic [`DATA_WIDTH-1:0] bus;
    logic [`DATA_WIDTH-1:0] regData;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] memData;
    logic [`DATA_WIDTH-1:0] yValue;
    logic [`DATA_WIDTH-1:0] marAddress;
    logic [`DATA_WIDTH-1:0] mdrValue;

    controlSequencer u_controlSequencer (.Clock, .reset, .instruction, .control, .halted);

    busDatapath u_busDatapath (.Clock, .reset, .control, .regData, .aluResult, .memData,
        .bus, .yValue, .marAddress, .mdrValue, .outData, .instruction, .outValid);

    registerFile u_registerFile (.Clock, .reset, .control, .instruction, .bus, .regData);

    aluUnit u_aluUnit (.yValue, .bus, .aluOp(control.aluOp), .incPc(control.incPc), .aluResult);

    memory512x32 u_memory512x32 (.Clock, .reset, .memRead(control.memRead),
        .memWrite(control.memWrite), .loadEnable, .address(marAddress[`ADDR_WIDTH-1:0]),
        .loadAddress, .writeData(mdrValue), .loadData, .readData(memData));

endmodule

//--- dv/miniCpuTb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module miniCpuTb;

    localparam int ClockPeriod = 20;
    localparam int DriveDelay = 2;      // After the rising edge
    localparam int SampleDelay = 1;
    localparam int MinResetCycles = 16;
    localparam int HaltWatchCycles = 20;
    localparam int TimeoutMargin = 100;

    logic                   Clock;
    logic                   reset;
    logic                   loadEnable;
    logic [`ADDR_WIDTH-1:0] loadAddress;
    logic [`DATA_WIDTH-1:0] loadData;
    logic [`DATA_WIDTH-1:0] outData;
    logic                   outValid;
    logic                   halted;

    logic [`DATA_WIDTH-1:0] traceWords [0:255];
    int preloadCount;
    int expectCount;
    int instrCount;
    int resetCycles;
    int timeoutLimit;
    int cycleCount = 0;
    int outIndex = 0;
    int testCount = 0;
    int failCount = 0;
    bit timedOut = 0;
    bit haltHeld;

    miniCpu u_miniCpu (.Clock, .reset, .loadEnable, .loadAddress, .loadData,
        .outData, .outValid, .halted);

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    always @(posedge Clock) cycleCount <= cycleCount + 1;

    // Compare one outValid pulse with the next expected trace value
    task automatic checkOutPulse(input logic [`DATA_WIDTH-1:0] value);
        logic [`DATA_WIDTH-1:0] expected;
        testCount++;
        if (outIndex >= expectCount) begin
            $display("extra outValid pulse after all %0d expected values, outData 0x%08h",
                expectCount, value);
            failCount++;
        end else begin
            expected = traceWords[3 + 2 * preloadCount + outIndex];
            if (value !== expected) begin
                $display("mismatch outData at out %0d: expected 0x%08h, got 0x%08h",
                    outIndex, expected, value);
                failCount++;
            end else begin
                $display("out %0d passed: outData 0x%08h", outIndex, value);
            end
            outIndex++;
        end
    endtask

    // Hold reset while the trace records go into memory
    task automatic preloadMemory();
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge Clock);
            #DriveDelay;
            if (i < preloadCount) begin
                loadEnable  = 1'b1;
                loadAddress = traceWords[3 + 2 * i][`ADDR_WIDTH-1:0];
                loadData    = traceWords[4 + 2 * i];
            end else begin
                loadEnable = 1'b0;
            end
            if (i == resetCycles - 1) reset = 1'b0; // Last record already written
        end
    endtask

    initial begin
        reset       = 1'b1;
        loadEnable  = 1'b0;
        loadAddress = '0;
        loadData    = '0;
        $readmemh("dv/miniCpu_trace.txt", traceWords);
        preloadCount = traceWords[0];
        expectCount  = traceWords[1];
        instrCount   = traceWords[2];
        resetCycles  = (preloadCount + 1 > MinResetCycles) ? preloadCount + 1 : MinResetCycles;
        timeoutLimit = instrCount * 10 + resetCycles + TimeoutMargin;

        preloadMemory();

        while (!halted && !timedOut) begin
            @(posedge Clock);
            #SampleDelay;
            if (outValid) checkOutPulse(outData);
            if (!halted && cycleCount >= timeoutLimit) timedOut = 1'b1;
        end

        // halted must hold with the out port silent
        testCount++;
        if (timedOut) begin
            $display("timeout: halted did not rise within %0d cycles", timeoutLimit);
            failCount++;
        end else begin
            haltHeld = 1'b1;
            for (int i = 0; i < HaltWatchCycles; i++) begin
                @(posedge Clock);
                #SampleDelay;
                if (outValid) checkOutPulse(outData);
                if (!halted) haltHeld = 1'b0;
            end
            if (!haltHeld) begin
                $display("halt test failed: halted fell before the end of the run");
                failCount++;
            end else begin
                $display("halt test passed at cycle %0d", cycleCount);
            end
        end

        testCount++;
        if (outIndex != expectCount) begin
            $display("order test failed: only %0d of %0d out-port values arrived",
                outIndex, expectCount);
            failCount++;
        end else begin
            $display("order test passed: %0d out-port values in program order", outIndex);
        end

        $display("%0d tests, %0d passed, %0d failed", testCount, testCount - failCount,
            failCount);
        if (failCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- miniCpu.f
+incdir+include
src/cpuPkg.sv
src/registerFile.sv
src/aluUnit.sv
src/busDatapath.sv
src/controlSequencer.sv
src/memory512x32.sv
src/miniCpu.sv
dv/miniCpuTb.sv

//--- dv/miniCpu_trace.txt
// Header: preload record count, out-port value count, instructions executed (all hex)
// Then one preload record per line as address and data, then expected out-port values in order
17 09 15
000 61000123 // ADDI r1, r0, 0x123
001 B9000000 // OUT r1
002 720000F0 // ORI r2, r0, 0xF0
003 BA000000 // OUT r2
004 6303FFFB // ADDI r3, r0, -5
005 1C2C0000 // ADD r4, r1, r3
006 BC000000 // OUT r4
007 25440000 // SUB r5, r2, r1
008 BD000000 // OUT r5
009 56280000 // AND r6, r1, r2
00A BE000000 // OUT r6
00B 5F280000 // OR r7, r1, r2
00C BF000000 // OUT r7
00D 01000040 // LD r1, 0x40(r0)
00E B9000000 // OUT r1
00F 02E3FE4E // LD r2, -0x1B2(r7) lands on 0x41
010 BA000000 // OUT r2
011 15000050 // ST r5, 0x50(r0)
012 03000050 // LD r3, 0x50(r0)
013 BB000000 // OUT r3
014 D8000000 // HALT
040 DEADBEEF // Data words
041 12345678
// Expected out-port values
00000123 000000F0 0000011E
FFFFFFCD 00000020 000001F3
DEADBEEF 12345678 FFFFFFCD
